/* src/memory_request_pkg.sv */
`default_nettype none

// ------------------------------------------------------------
// Shared sizing for the memory request merge path
// ------------------------------------------------------------
package memory_request_pkg;

  // Engines feeding the arbiter
  localparam int NUM_REQUESTORS = 4;

  // Index into the requestor set
  localparam int REQUESTOR_INDEX_WIDTH = 2;

  // One memory request word
  // Opaque here since the command layout lives in the engines
  localparam int PAYLOAD_WIDTH = 64;

  // ------------------------------------------------------------
  // Per-requestor queues
  // ------------------------------------------------------------
  // Entries per requestor queue
  localparam int QUEUE_DEPTH = 16;

  // Almost-full level for a requestor queue
  // Leaves 4 entries for requests still in flight after grant drops
  localparam int QUEUE_PROG_THRESH = 12;

  // ------------------------------------------------------------
  // Egress queue toward the memory port
  // ------------------------------------------------------------
  // Entries in the egress queue
  localparam int EGRESS_DEPTH = 32;

  // Almost-full level for the egress queue
  // Slack covers pops already in the arbiter pipeline
  localparam int EGRESS_PROG_THRESH = 24;

endpackage : memory_request_pkg

`default_nettype wire

/* src/request_queue.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// Synchronous FIFO with read valid and almost-full
// ------------------------------------------------------------
module request_queue #(
  parameter int DEPTH       = memory_request_pkg::QUEUE_DEPTH,
  parameter int PROG_THRESH = memory_request_pkg::QUEUE_PROG_THRESH
) (
  input  logic                                     ap_clk,
  input  logic                                     areset_control,
  input  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] din,
  input  logic                                     wr_en,
  input  logic                                     rd_en,
  output logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] dout,
  output logic                                     valid,
  output logic                                     empty,
  output logic                                     full,
  output logic                                     prog_full
);

  import memory_request_pkg::*;

  // Storage array
  logic [PAYLOAD_WIDTH-1:0] mem [DEPTH];

  // Pointers and occupancy
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic [$clog2(DEPTH+1)-1:0] count_next;

  // Accepted operations
  logic do_write;
  logic do_read;

  // Writes while full and reads while empty are dropped
  assign do_write = wr_en & ~full;
  assign do_read  = rd_en & ~empty;

  // Occupancy after this cycle
  always_comb begin
    case ({do_write, do_read})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // ------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointer wrap for any depth
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------
  // Registered read data held between pops
  always_ff @(posedge ap_clk) begin
    if (do_read) begin
      dout <= mem[rd_ptr];
    end
  end

  // One-cycle valid per accepted read
  // Flags come from next occupancy so they track the same edge
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      valid     <= 1'b0;
      count     <= '0;
      empty     <= 1'b1;
      full      <= 1'b0;
      prog_full <= 1'b0;
    end else begin
      valid     <= do_read;
      count     <= count_next;
      empty     <= (count_next == 0);
      full      <= (count_next == DEPTH);
      prog_full <= (count_next >= PROG_THRESH);
    end
  end

endmodule : request_queue

`default_nettype wire

/* src/round_robin_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// Rotating-priority pop of the requestor queues
// ------------------------------------------------------------
module round_robin_arbiter (
  input  logic                                         ap_clk,
  input  logic                                         areset_control,
  input  logic [memory_request_pkg::NUM_REQUESTORS-1:0] queue_empty,
  input  logic [memory_request_pkg::NUM_REQUESTORS-1:0] queue_valid,
  input  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]
                 queue_dout [memory_request_pkg::NUM_REQUESTORS],
  input  logic                                         egress_prog_full,
  output logic [memory_request_pkg::NUM_REQUESTORS-1:0] queue_rd_en,
  output logic                                         arb_valid,
  output logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  arb_payload
);

  import memory_request_pkg::*;

  // Search start one past the last winner
  logic [REQUESTOR_INDEX_WIDTH-1:0] prio;

  // Queue popped in the previous cycle
  logic [NUM_REQUESTORS-1:0] last_rd_en;

  // Candidates this cycle
  logic [NUM_REQUESTORS-1:0] eligible;

  // Search result
  logic                             found;
  logic [REQUESTOR_INDEX_WIDTH-1:0] winner;
  logic                             pop;

  // Previous winner sits out one cycle
  assign eligible = ~queue_empty & ~last_rd_en;

  // First eligible queue at or after prio
  always_comb begin
    logic [REQUESTOR_INDEX_WIDTH-1:0] idx;
    found  = 1'b0;
    winner = prio;
    for (int k = 0; k < NUM_REQUESTORS; k++) begin
      idx = prio + REQUESTOR_INDEX_WIDTH'(k);
      if (!found && eligible[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
  end

  // No pops while the egress queue is near full
  assign pop = found & ~egress_prog_full;

  // One-hot pop toward the queues
  always_comb begin
    queue_rd_en = '0;
    if (pop) begin
      queue_rd_en[winner] = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Priority state
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      prio       <= '0;
      last_rd_en <= '0;
    end else begin
      last_rd_en <= queue_rd_en;
      if (pop) begin
        prio <= winner + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Winner capture
  // ------------------------------------------------------------
  // At most one queue valid per cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arb_valid <= 1'b0;
    end else begin
      arb_valid <= |queue_valid;
    end
  end

  // Payload from whichever queue returned data
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (queue_valid[i]) begin
        arb_payload <= queue_dout[i];
      end
    end
  end

endmodule : round_robin_arbiter

`default_nettype wire

/* src/request_egress.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// Egress stage toward the memory port
// ------------------------------------------------------------
module request_egress (
  input  logic                                        ap_clk,
  input  logic                                        areset_control,
  input  logic                                        arb_valid,
  input  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] arb_payload,
  input  logic                                        out_rd_en,
  output logic                                        request_out_valid,
  output logic [memory_request_pkg::PAYLOAD_WIDTH-1:0] request_out_payload,
  output logic                                        out_empty,
  output logic                                        out_prog_full
);

  import memory_request_pkg::*;

  // Staged arbiter word
  logic                     stage_valid;
  logic [PAYLOAD_WIDTH-1:0] stage_payload;

  // Egress queue read side
  logic                     egress_rd_en;
  logic                     egress_valid;
  logic [PAYLOAD_WIDTH-1:0] egress_dout;

  // ------------------------------------------------------------
  // Staging register
  // ------------------------------------------------------------
  // Breaks the path from the arbiter mux into the queue
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= arb_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    stage_payload <= arb_payload;
  end

  // Pop only a non-empty queue
  assign egress_rd_en = out_rd_en & ~out_empty;

  // ------------------------------------------------------------
  // Egress queue
  // ------------------------------------------------------------
  request_queue #(
    .DEPTH      (EGRESS_DEPTH),
    .PROG_THRESH(EGRESS_PROG_THRESH)
  ) u_egress_queue (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (stage_payload),
    .wr_en         (stage_valid),
    .rd_en         (egress_rd_en),
    .dout          (egress_dout),
    .valid         (egress_valid),
    .empty         (out_empty),
    .full          (),
    .prog_full     (out_prog_full)
  );

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  // Second cycle of the read latency
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_out_valid <= 1'b0;
    end else begin
      request_out_valid <= egress_valid;
    end
  end

  // Payload follows the queue word
  always_ff @(posedge ap_clk) begin
    request_out_payload <= egress_dout;
  end

endmodule : request_egress

`default_nettype wire

/* src/memory_request_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// Top level of the N to 1 memory request merge
// ------------------------------------------------------------
module memory_request_arbiter (
  input  logic                                         ap_clk,
  input  logic                                         areset_control,
  input  logic [memory_request_pkg::NUM_REQUESTORS-1:0] request_in_valid,
  input  logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]
                 request_in_payload [memory_request_pkg::NUM_REQUESTORS],
  output logic [memory_request_pkg::NUM_REQUESTORS-1:0] request_grant,
  input  logic                                         out_rd_en,
  output logic                                         request_out_valid,
  output logic [memory_request_pkg::PAYLOAD_WIDTH-1:0]  request_out_payload,
  output logic                                         out_empty,
  output logic                                         out_prog_full
);

  import memory_request_pkg::*;

  // Delayed reset shared by every block below
  logic areset_control_q;

  // Input register stage
  logic [NUM_REQUESTORS-1:0] in_valid_q;
  logic [PAYLOAD_WIDTH-1:0]  in_payload_q [NUM_REQUESTORS];

  // Requestor queue status and data
  logic [NUM_REQUESTORS-1:0] queue_rd_en;
  logic [NUM_REQUESTORS-1:0] queue_empty;
  logic [NUM_REQUESTORS-1:0] queue_valid;
  logic [NUM_REQUESTORS-1:0] queue_prog_full;
  logic [PAYLOAD_WIDTH-1:0]  queue_dout [NUM_REQUESTORS];

  // Arbiter winner
  logic                     arb_valid;
  logic [PAYLOAD_WIDTH-1:0] arb_payload;

  // ------------------------------------------------------------
  // Reset and input registers
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    areset_control_q <= areset_control;
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control_q) begin
      in_valid_q <= '0;
    end else begin
      in_valid_q <= request_in_valid;
    end
  end

  // Payload input register
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      in_payload_q[i] <= request_in_payload[i];
    end
  end

  // ------------------------------------------------------------
  // Per-requestor queues
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_REQUESTORS; i++) begin : gen_request_queue
    request_queue #(
      .DEPTH      (QUEUE_DEPTH),
      .PROG_THRESH(QUEUE_PROG_THRESH)
    ) u_request_queue (
      .ap_clk        (ap_clk),
      .areset_control(areset_control_q),
      .din           (in_payload_q[i]),
      .wr_en         (in_valid_q[i]),
      .rd_en         (queue_rd_en[i]),
      .dout          (queue_dout[i]),
      .valid         (queue_valid[i]),
      .empty         (queue_empty[i]),
      .full          (),
      .prog_full     (queue_prog_full[i])
    );
  end

  // ------------------------------------------------------------
  // Arbiter and egress
  // ------------------------------------------------------------
  round_robin_arbiter u_round_robin_arbiter (
    .ap_clk          (ap_clk),
    .areset_control  (areset_control_q),
    .queue_empty     (queue_empty),
    .queue_valid     (queue_valid),
    .queue_dout      (queue_dout),
    .egress_prog_full(out_prog_full),
    .queue_rd_en     (queue_rd_en),
    .arb_valid       (arb_valid),
    .arb_payload     (arb_payload)
  );

  request_egress u_request_egress (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control_q),
    .arb_valid          (arb_valid),
    .arb_payload        (arb_payload),
    .out_rd_en          (out_rd_en),
    .request_out_valid  (request_out_valid),
    .request_out_payload(request_out_payload),
    .out_empty          (out_empty),
    .out_prog_full      (out_prog_full)
  );

  // Grant drops on own queue or egress near full
  // Held low through both the port and the delayed reset cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control || areset_control_q) begin
      request_grant <= '0;
    end else begin
      request_grant <= ~queue_prog_full & {NUM_REQUESTORS{~out_prog_full}};
    end
  end

endmodule : memory_request_arbiter

`default_nettype wire

/* test/memory_request_arbiter_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// Port protocol assertions for the request merge top level
// ------------------------------------------------------------
module memory_request_arbiter_checker (
  input logic                                         ap_clk,
  input logic                                         areset_control,
  input logic                                         areset_control_q,
  input logic [memory_request_pkg::NUM_REQUESTORS-1:0] request_in_valid,
  input logic [memory_request_pkg::NUM_REQUESTORS-1:0] request_grant,
  input logic                                         out_rd_en,
  input logic                                         request_out_valid
);

  import memory_request_pkg::*;

  // Count of failed assertions
  int failure_count = 0;

  // Grants held at zero once both reset copies are high
  assert property (@(posedge ap_clk)
    areset_control && areset_control_q |-> request_grant == '0)
    else begin
      $error("request_grant not zero during reset");
      failure_count++;
    end

  // Output idle right after reset
  assert property (@(posedge ap_clk) $fell(areset_control) |-> !request_out_valid)
    else begin
      $error("request_out_valid high on the cycle after reset");
      failure_count++;
    end

  // Two cycles for queue read and output register
  assert property (@(posedge ap_clk) disable iff (areset_control)
    request_out_valid |-> $past(out_rd_en, 2))
    else begin
      $error("request_out_valid without out_rd_en two cycles earlier");
      failure_count++;
    end

  // Requestor may only send on a recent grant
  for (genvar i = 0; i < NUM_REQUESTORS; i++) begin : gen_grant_check
    assert property (@(posedge ap_clk) disable iff (areset_control)
      request_in_valid[i] |-> (request_grant[i] || $past(request_grant[i], 1)
                               || $past(request_grant[i], 2) || $past(request_grant[i], 3)))
      else begin
        $error("request_in_valid[%0d] without a grant in the last 4 cycles", i);
        failure_count++;
      end
  end

endmodule : memory_request_arbiter_checker

bind memory_request_arbiter memory_request_arbiter_checker checker_i (
  .ap_clk           (ap_clk),
  .areset_control   (areset_control),
  .areset_control_q (areset_control_q),
  .request_in_valid (request_in_valid),
  .request_grant    (request_grant),
  .out_rd_en        (out_rd_en),
  .request_out_valid(request_out_valid)
);

`default_nettype wire

/* test/memory_request_arbiter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_request_arbiter_tb;

  import memory_request_pkg::*;

  // ------------------------------------------------------------
  // Run lengths and stimulus modes
  // ------------------------------------------------------------
  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DELAY   = 2;
  localparam int RESET_CYCLES  = 2;
  localparam int RANDOM_CYCLES = 500;
  localparam int SAT_WARMUP    = 80;
  localparam int SAT_CYCLES    = 400;
  localparam int HOLD_CYCLES   = 120;
  localparam int RESUME_CYCLES = 130;
  // Worst drain is a few full queues at one word per cycle
  localparam int DRAIN_MARGIN  = 400;
  localparam int CYCLE_LIMIT   = RESET_CYCLES + RANDOM_CYCLES + SAT_CYCLES
                                 + 2 * (HOLD_CYCLES + RESUME_CYCLES) + DRAIN_MARGIN;
  // Index on top then sequence then random bits
  localparam int SEQ_WIDTH     = 8;
  localparam int SEQ_LSB       = PAYLOAD_WIDTH - REQUESTOR_INDEX_WIDTH - SEQ_WIDTH;
  localparam int MODE_RANDOM   = 0;
  localparam int MODE_SATURATE = 1;
  localparam int MODE_HOLD     = 2;
  localparam int MODE_DRAIN    = 3;

  logic                      ap_clk;
  logic                      areset_control;
  logic [NUM_REQUESTORS-1:0] request_in_valid;
  logic [PAYLOAD_WIDTH-1:0]  request_in_payload [NUM_REQUESTORS];
  logic [NUM_REQUESTORS-1:0] request_grant;
  logic                      out_rd_en;
  logic                      request_out_valid;
  logic [PAYLOAD_WIDTH-1:0]  request_out_payload;
  logic                      out_empty;
  logic                      out_prog_full;

  // Scoreboard of expected payloads per requestor
  logic [PAYLOAD_WIDTH-1:0] expected_q [NUM_REQUESTORS][$];
  logic [SEQ_WIDTH-1:0]     in_seq  [NUM_REQUESTORS];
  logic [SEQ_WIDTH-1:0]     out_seq [NUM_REQUESTORS];

  logic [31:0]               lfsr;
  int                        mode_now;
  int                        cycle_count;
  int                        mismatch_errors;
  int                        protocol_errors;
  int                        fairness_errors;
  int                        total_errors;
  logic                      fairness_on;
  logic [NUM_REQUESTORS-1:0] round_mask;
  logic                      saw_prog_full;
  logic                      saw_grants_low;

  memory_request_arbiter dut_i (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .request_in_valid   (request_in_valid),
    .request_in_payload (request_in_payload),
    .request_grant      (request_grant),
    .out_rd_en          (out_rd_en),
    .request_out_valid  (request_out_valid),
    .request_out_payload(request_out_payload),
    .out_empty          (out_empty),
    .out_prog_full      (out_prog_full)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // ------------------------------------------------------------
  // Random bits
  // ------------------------------------------------------------
  // Taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic step_lfsr();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [PAYLOAD_WIDTH-1:0] gather_bits(input int n);
    logic [PAYLOAD_WIDTH-1:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[PAYLOAD_WIDTH-2:0], step_lfsr()};
    end
    return v;
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      n += expected_q[i].size();
    end
    return n;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_payload(input string name, input logic [PAYLOAD_WIDTH-1:0] got,
                               input logic [PAYLOAD_WIDTH-1:0] expected);
    if (got !== expected) begin
      mismatch_errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      mismatch_errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected);
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  // Send only on the grant registered at this edge
  task automatic drive_requests(input int mode);
    logic                     send;
    logic [PAYLOAD_WIDTH-1:0] p;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      send = 1'b0;
      if (mode == MODE_SATURATE) begin
        send = (request_grant[i] === 1'b1);
      end else if (mode != MODE_DRAIN && request_grant[i] === 1'b1) begin
        send = step_lfsr();
      end
      request_in_valid[i] = send;
      if (send) begin
        p = gather_bits(SEQ_LSB);
        p[PAYLOAD_WIDTH-1 -: REQUESTOR_INDEX_WIDTH] = REQUESTOR_INDEX_WIDTH'(i);
        p[SEQ_LSB +: SEQ_WIDTH] = in_seq[i];
        request_in_payload[i] = p;
        expected_q[i].push_back(p);
        in_seq[i]++;
      end
    end
  endtask

  task automatic run_cycles(input int n, input int mode);
    mode_now = mode;
    for (int c = 0; c < n; c++) begin
      @(posedge ap_clk);
      #DRIVE_DELAY;
      drive_requests(mode);
      case (mode)
        MODE_HOLD:   out_rd_en = 1'b0;
        MODE_RANDOM: out_rd_en = step_lfsr();
        default:     out_rd_en = 1'b1;
      endcase
    end
  endtask

  // ------------------------------------------------------------
  // Output monitor at mid-cycle
  // ------------------------------------------------------------
  task automatic score_output(input logic [PAYLOAD_WIDTH-1:0] payload);
    int                       idx;
    logic [PAYLOAD_WIDTH-1:0] expected;
    idx = int'(payload[PAYLOAD_WIDTH-1 -: REQUESTOR_INDEX_WIDTH]);
    if (expected_q[idx].size() == 0) begin
      protocol_errors++;
      $display("Output 0x%h for requestor %0d with nothing pending", payload, idx);
    end else begin
      expected = expected_q[idx].pop_front();
      check_payload("request_out_payload", payload, expected);
      check_payload("request_out_payload sequence",
                    PAYLOAD_WIDTH'(payload[SEQ_LSB +: SEQ_WIDTH]),
                    PAYLOAD_WIDTH'(out_seq[idx]));
      out_seq[idx]++;
    end
    // Each index once per round under saturation
    if (fairness_on) begin
      if (round_mask == '1) begin
        round_mask = '0;
      end
      if (round_mask[idx]) begin
        fairness_errors++;
        $display("Requestor %0d served twice in one arbitration round", idx);
      end
      round_mask[idx] = 1'b1;
    end
  endtask

  always @(negedge ap_clk) begin
    if (areset_control === 1'b0) begin
      if (request_out_valid === 1'b1) begin
        score_output(request_out_payload);
      end
      if (mode_now == MODE_HOLD && out_prog_full === 1'b1) begin
        saw_prog_full = 1'b1;
        if (request_grant === '0) begin
          saw_grants_low = 1'b1;
        end
      end
    end
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, %0d requests never came out",
             CYCLE_LIMIT, pending_total());
    $display("TB FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    areset_control   = 1'b1;
    request_in_valid = '0;
    out_rd_en        = 1'b0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      request_in_payload[i] = '0;
      in_seq[i]             = '0;
      out_seq[i]            = '0;
    end
    lfsr            = 32'd93465;
    mode_now        = MODE_DRAIN;
    mismatch_errors = 0;
    protocol_errors = 0;
    fairness_errors = 0;
    fairness_on     = 1'b0;
    round_mask      = '0;
    saw_prog_full   = 1'b0;
    saw_grants_low  = 1'b0;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #DRIVE_DELAY;
    check_flag("request_out_valid", request_out_valid, 1'b0);
    check_flag("out_empty", out_empty, 1'b1);
    check_flag("out_prog_full", out_prog_full, 1'b0);
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      check_flag($sformatf("request_grant[%0d]", i), request_grant[i], 1'b0);
    end
    areset_control = 1'b0;
    run_cycles(RANDOM_CYCLES, MODE_RANDOM);
    // Saturation with rotation checked once the egress holds only these pops
    run_cycles(SAT_WARMUP, MODE_SATURATE);
    round_mask  = '0;
    fairness_on = 1'b1;
    run_cycles(SAT_CYCLES - SAT_WARMUP, MODE_SATURATE);
    fairness_on = 1'b0;
    // Memory side stalls and then resumes
    repeat (2) begin
      run_cycles(HOLD_CYCLES, MODE_HOLD);
      run_cycles(RESUME_CYCLES, MODE_RANDOM);
    end
    check_flag("out_prog_full during stall", saw_prog_full, 1'b1);
    check_flag("request_grant all low during stall", saw_grants_low, 1'b1);
    while (pending_total() != 0) begin
      run_cycles(1, MODE_DRAIN);
    end
    run_cycles(8, MODE_DRAIN);
    check_flag("out_empty after drain", out_empty, 1'b1);
    total_errors = mismatch_errors + protocol_errors + fairness_errors
                   + dut_i.checker_i.failure_count;
    $display("Errors: %0d mismatch, %0d protocol, %0d fairness, %0d assertion",
             mismatch_errors, protocol_errors, fairness_errors,
             dut_i.checker_i.failure_count);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : memory_request_arbiter_tb

`default_nettype wire

/* memory_request_arbiter.f */
src/memory_request_pkg.sv
src/request_queue.sv
src/round_robin_arbiter.sv
src/request_egress.sv
src/memory_request_arbiter.sv
test/memory_request_arbiter_checker.sv
test/memory_request_arbiter_tb.sv

/* Bender.yml */
package:
  name: memory_request_arbiter

sources:
  - files:
      - src/memory_request_pkg.sv
      - src/request_queue.sv
      - src/round_robin_arbiter.sv
      - src/request_egress.sv
      - src/memory_request_arbiter.sv
  - target: test
    files:
      - test/memory_request_arbiter_checker.sv
      - test/memory_request_arbiter_tb.sv
